//--- verilog.f
rtl/safety_island_pkg.sv
rtl/mem_bus_if.sv
rtl/bus_xbar.sv
rtl/sram_bank.sv
rtl/periph_demux.sv
rtl/soc_ctrl_regs.sv
rtl/safety_island_top.sv
sim/tb_safety_island.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_safety_island -f verilog.f

status=0
out=$(./obj_dir/Vtb_safety_island 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1

//--- sim/tb_safety_island.sv
// ----------------------------------------------------------
// Safety island testbench
// Directed tests for boot state, SRAM banks, control
// registers, error responses and arbitration
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_safety_island import safety_island_pkg::*; ();

  localparam int unsigned BankBytes     = 4096;
  localparam int unsigned RefWords      = 2 * BankBytes / 4;
  localparam int unsigned TimeoutCycles = 200;
  localparam addr_t       CtrlBase      = PeriphOffset + SocCtrlOffset;
  localparam addr_t       BootAddrExp   = PeriphOffset + BootRomOffset + 32'h80;

  logic      clk;
  logic      rst_n;
  bootmode_e bootmode;
  logic      fetch_enable_o;
  addr_t     boot_addr_o;

  // Ports of initiators 0 and 1
  logic  mreq    [2];
  logic  mwe     [2];
  be_t   mbe     [2];
  addr_t maddr   [2];
  data_t mwdata  [2];
  logic  mgnt    [2];
  logic  mrvalid [2];
  logic  merr    [2];
  data_t mrdata  [2];

  // Expected contents of both banks
  data_t  ref_mem [RefWords];
  integer seed   = 32'h5541_e6f3;

  safety_island_top dut_i (
    .clk_i (clk), .rst_ni (rst_n),
    .m0_req_i (mreq[0]), .m0_we_i (mwe[0]), .m0_be_i (mbe[0]),
    .m0_addr_i (maddr[0]), .m0_wdata_i (mwdata[0]),
    .m0_gnt_o (mgnt[0]), .m0_rvalid_o (mrvalid[0]), .m0_err_o (merr[0]),
    .m0_rdata_o (mrdata[0]),
    .m1_req_i (mreq[1]), .m1_we_i (mwe[1]), .m1_be_i (mbe[1]),
    .m1_addr_i (maddr[1]), .m1_wdata_i (mwdata[1]),
    .m1_gnt_o (mgnt[1]), .m1_rvalid_o (mrvalid[1]), .m1_err_o (merr[1]),
    .m1_rdata_o (mrdata[1]),
    .bootmode_i (bootmode), .fetch_enable_o (fetch_enable_o), .boot_addr_o (boot_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %08h, expected %08h", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  task automatic drive_idle(input int p);
    mreq[p]   = 1'b0;
    mwe[p]    = 1'b0;
    mbe[p]    = '0;
    maddr[p]  = '0;
    mwdata[p] = '0;
  endtask

  function automatic void ref_write(input addr_t addr, input data_t wdata, input be_t be);
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        ref_mem[addr[12:2]][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endfunction

  // Hold req until gnt and then take the response
  task automatic bus_access(input int p, input logic we, input addr_t addr, input data_t wdata,
                            input be_t be, output data_t rdata, output logic err,
                            output time gnt_t);
    int waited;
    @(posedge clk);
    #1;
    mreq[p]   = 1'b1;
    mwe[p]    = we;
    mbe[p]    = be;
    maddr[p]  = addr;
    mwdata[p] = wdata;
    waited = 0;
    @(negedge clk);
    while (!mgnt[p]) begin
      if (waited == TimeoutCycles) begin
        $display("timeout: initiator %0d never granted for address %08h", p, addr);
        stop_on_error();
      end
      waited++;
      @(negedge clk);
    end
    gnt_t = $time;
    @(posedge clk);
    #1;
    drive_idle(p);
    waited = 0;
    @(negedge clk);
    while (!mrvalid[p]) begin
      if (waited == TimeoutCycles) begin
        $display("timeout: no response on initiator %0d for address %08h", p, addr);
        stop_on_error();
      end
      waited++;
      @(negedge clk);
    end
    rdata = mrdata[p];
    err   = merr[p];
  endtask

  task automatic bus_write(input int p, input addr_t addr, input data_t wdata, input be_t be,
                           output logic err);
    data_t rdata;
    time   gnt_t;
    bus_access(p, 1'b1, addr, wdata, be, rdata, err, gnt_t);
  endtask

  task automatic bus_read(input int p, input addr_t addr, output data_t rdata, output logic err);
    time gnt_t;
    bus_access(p, 1'b0, addr, '0, '0, rdata, err, gnt_t);
  endtask

  task automatic apply_reset(input bootmode_e mode);
    @(posedge clk);
    #1;
    rst_n    = 1'b0;
    bootmode = mode;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_boot_state(input bootmode_e mode);
    data_t rdata;
    logic  err;
    apply_reset(mode);
    check_value(data_t'(fetch_enable_o), data_t'(mode == BootJtag), "fetch enable after reset");
    check_value(boot_addr_o, BootAddrExp, "boot address after reset");
    bus_read(0, CtrlBase + addr_t'(RegBootMode), rdata, err);
    check_value(rdata, data_t'(mode), "boot mode register");
    check_value(data_t'(err), 32'h0, "boot mode read err");
  endtask

  task automatic test_bank_access();
    addr_t addrs [8] = '{32'h0, 32'h4, 32'h3f0, 32'hffc, 32'h1000, 32'h1004, 32'h1800, 32'h1ffc};
    data_t wdata;
    data_t rdata;
    be_t   be;
    logic  err;
    for (int i = 0; i < 8; i++) begin
      wdata = data_t'($random(seed));
      bus_write(i % 2, addrs[i], wdata, 4'hf, err);
      ref_write(addrs[i], wdata, 4'hf);
      check_value(data_t'(err), 32'h0, "bank full write err");
      // Partial overwrite from the other initiator
      wdata = data_t'($random(seed));
      be    = be_t'($random(seed));
      bus_write(1 - i % 2, addrs[i], wdata, be, err);
      ref_write(addrs[i], wdata, be);
      check_value(data_t'(err), 32'h0, "bank partial write err");
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(i % 2, addrs[i], rdata, err);
      check_value(rdata, ref_mem[addrs[i][12:2]], "bank readback");
      check_value(data_t'(err), 32'h0, "bank read err");
    end
  endtask

  task automatic test_ctrl_regs();
    data_t rdata;
    logic  err;
    bus_write(1, CtrlBase + addr_t'(RegBootAddr), 32'h1234_5680, 4'hf, err);
    check_value(data_t'(err), 32'h0, "boot address write err");
    check_value(boot_addr_o, 32'h1234_5680, "boot address output");
    bus_read(0, CtrlBase + addr_t'(RegBootAddr), rdata, err);
    check_value(rdata, 32'h1234_5680, "boot address readback");
    // Fetch enable is low after the preload reset
    bus_write(1, CtrlBase + addr_t'(RegFetchEn), 32'h1, 4'hf, err);
    bus_write(0, CtrlBase + addr_t'(RegFetchEn), 32'h0, 4'hf, err);
    check_value(data_t'(fetch_enable_o), 32'h0, "fetch enable cleared");
    bus_write(0, CtrlBase + addr_t'(RegFetchEn), 32'h1, 4'hf, err);
    check_value(data_t'(fetch_enable_o), 32'h1, "fetch enable set");
    // Boot mode keeps the preload value of the last reset
    bus_write(1, CtrlBase + addr_t'(RegBootMode), data_t'(BootFlash), 4'hf, err);
    bus_read(1, CtrlBase + addr_t'(RegBootMode), rdata, err);
    check_value(rdata, data_t'(BootPreload), "boot mode after write");
  endtask

  task automatic test_error_resp();
    addr_t bad [2] = '{PeriphOffset + 32'h4000, AddrRange + 32'h100};
    data_t rdata;
    logic  err;
    for (int i = 0; i < 2; i++) begin
      bus_write(i, bad[i], 32'hdead_beef, 4'hf, err);
      check_value(data_t'(err), 32'h1, "unmapped write err");
      bus_read(1 - i, bad[i], rdata, err);
      check_value(data_t'(err), 32'h1, "unmapped read err");
      check_value(rdata, ErrorRdata, "unmapped read data");
    end
  endtask

  task automatic test_contention();
    data_t d0;
    data_t d1;
    data_t r0;
    data_t r1;
    logic  e0;
    logic  e1;
    time   t0;
    time   t1;
    apply_reset(BootJtag);
    d0 = data_t'($random(seed));
    d1 = data_t'($random(seed));
    fork
      bus_access(0, 1'b1, 32'h20, d0, 4'hf, r0, e0, t0);
      bus_access(1, 1'b1, 32'h24, d1, 4'hf, r1, e1, t1);
    join
    ref_write(32'h20, d0, 4'hf);
    ref_write(32'h24, d1, 4'hf);
    check_value(data_t'(t0 < t1), 32'h1, "initiator 0 granted before initiator 1");
    bus_read(1, 32'h20, r0, e0);
    check_value(r0, ref_mem[32'h20 >> 2], "contention write of initiator 0");
    bus_read(0, 32'h24, r1, e1);
    check_value(r1, ref_mem[32'h24 >> 2], "contention write of initiator 1");
  endtask

  task automatic traffic_loop(input int p, input addr_t base, input int count);
    addr_t addr;
    data_t wdata;
    data_t rdata;
    logic  err;
    for (int k = 0; k < count; k++) begin
      addr  = base + addr_t'(4 * k);
      wdata = data_t'($random(seed));
      bus_write(p, addr, wdata, 4'hf, err);
      ref_write(addr, wdata, 4'hf);
      check_value(data_t'(err), 32'h0, "parallel write err");
      bus_read(p, addr, rdata, err);
      check_value(rdata, ref_mem[addr[12:2]], "parallel readback");
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    bootmode = BootJtag;
    drive_idle(0);
    drive_idle(1);
    test_boot_state(BootJtag);
    test_boot_state(BootPreload);
    test_bank_access();
    test_ctrl_regs();
    test_error_resp();
    test_contention();
    fork
      traffic_loop(0, 32'h0000_0200, 16);
      traffic_loop(1, 32'h0000_1200, 16);
    join
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- rtl/safety_island_top.sv
// ----------------------------------------------------------
// Safety island memory subsystem
// Two bus initiators share a crossbar onto two SRAM banks
// and the peripheral region with the SoC control registers
// ----------------------------------------------------------

`timescale 1ns/1ps

module safety_island_top import safety_island_pkg::*; #(
  parameter addr_t       BaseAddr     = '0,
  parameter int unsigned BankNumBytes = 4096
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Initiator 0
  input  logic      m0_req_i,
  input  logic      m0_we_i,
  input  be_t       m0_be_i,
  input  addr_t     m0_addr_i,
  input  data_t     m0_wdata_i,
  output logic      m0_gnt_o,
  output logic      m0_rvalid_o,
  output logic      m0_err_o,
  output data_t     m0_rdata_o,

  // Initiator 1
  input  logic      m1_req_i,
  input  logic      m1_we_i,
  input  be_t       m1_be_i,
  input  addr_t     m1_addr_i,
  input  data_t     m1_wdata_i,
  output logic      m1_gnt_o,
  output logic      m1_rvalid_o,
  output logic      m1_err_o,
  output data_t     m1_rdata_o,

  input  bootmode_e bootmode_i,
  output logic      fetch_enable_o,
  output addr_t     boot_addr_o
);

  localparam addr_t       PeriphBaseAddr  = BaseAddr + PeriphOffset;
  localparam addr_t       BootAddrDefault = PeriphBaseAddr + BootRomOffset + 32'h80;
  localparam int unsigned BankNumWords    = BankNumBytes / 4;

  mem_bus_if init_bus [NumInitiators] ();
  mem_bus_if tgt_bus  [NumTargets] ();
  mem_bus_if ctrl_bus ();

  // ----------------------------------------------------------
  // Initiator ports
  // ----------------------------------------------------------
  assign init_bus[0].req   = m0_req_i;
  assign init_bus[0].we    = m0_we_i;
  assign init_bus[0].be    = m0_be_i;
  assign init_bus[0].addr  = m0_addr_i;
  assign init_bus[0].wdata = m0_wdata_i;
  assign m0_gnt_o          = init_bus[0].gnt;
  assign m0_rvalid_o       = init_bus[0].rvalid;
  assign m0_err_o          = init_bus[0].err;
  assign m0_rdata_o        = init_bus[0].rdata;

  assign init_bus[1].req   = m1_req_i;
  assign init_bus[1].we    = m1_we_i;
  assign init_bus[1].be    = m1_be_i;
  assign init_bus[1].addr  = m1_addr_i;
  assign init_bus[1].wdata = m1_wdata_i;
  assign m1_gnt_o          = init_bus[1].gnt;
  assign m1_rvalid_o       = init_bus[1].rvalid;
  assign m1_err_o          = init_bus[1].err;
  assign m1_rdata_o        = init_bus[1].rdata;

  // ----------------------------------------------------------
  // Interconnect and targets
  // ----------------------------------------------------------
  bus_xbar #(
    .BaseAddr     (BaseAddr),
    .BankNumBytes (BankNumBytes)
  ) i_xbar (
    .clk_i,
    .rst_ni,
    .init_i (init_bus),
    .tgt_o  (tgt_bus)
  );

  for (genvar b = 0; b < 2; b++) begin : gen_bank
    sram_bank #(
      .NumWords (BankNumWords)
    ) i_bank (
      .clk_i,
      .rst_ni,
      .bus (tgt_bus[b])
    );
  end

  periph_demux #(
    .PeriphBaseAddr (PeriphBaseAddr)
  ) i_periph_demux (
    .clk_i,
    .rst_ni,
    .bus  (tgt_bus[TgtPeriph]),
    .ctrl (ctrl_bus)
  );

  soc_ctrl_regs #(
    .BootAddrDefault (BootAddrDefault)
  ) i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .bus (ctrl_bus),
    .bootmode_i,
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

//--- rtl/soc_ctrl_regs.sv
// ----------------------------------------------------------
// SoC control registers
// Boot address, fetch enable and the boot mode sampled
// right after reset
// ----------------------------------------------------------

`timescale 1ns/1ps

module soc_ctrl_regs import safety_island_pkg::*; #(
  parameter addr_t BootAddrDefault = '0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  mem_bus_if.target bus,
  input  bootmode_e bootmode_i,
  output logic      fetch_enable_o,
  output addr_t     boot_addr_o
);

  logic [RegOffWidth-1:0] reg_off;
  addr_t                  boot_addr_q;
  logic                   fetch_en_q;
  bootmode_e              bootmode_q;
  logic                   first_q;
  logic                   rvalid_q;
  data_t                  rdata_d;
  data_t                  rdata_q;

  assign reg_off = bus.addr[RegOffWidth-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_addr_q <= BootAddrDefault;
      fetch_en_q  <= 1'b0;
      bootmode_q  <= BootJtag;
      first_q     <= 1'b1;
      rvalid_q    <= 1'b0;
    end else begin
      first_q  <= 1'b0;
      rvalid_q <= bus.req;
      // Sample boot pins once, JTAG boot starts fetching at once
      if (first_q) begin
        bootmode_q <= bootmode_i;
        fetch_en_q <= (bootmode_i == BootJtag);
      end
      if (bus.req && bus.we) begin
        if (reg_off == RegBootAddr) begin
          for (int b = 0; b < BeWidth; b++) begin
            if (bus.be[b]) begin
              boot_addr_q[8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end
        end
        if (reg_off == RegFetchEn && bus.be[0]) begin
          fetch_en_q <= bus.wdata[0];
        end
      end
    end
  end

  // Read mux, writes answer with zero
  always_comb begin
    rdata_d = '0;
    if (!bus.we) begin
      case (reg_off)
        RegBootAddr: rdata_d = boot_addr_q;
        RegFetchEn:  rdata_d = data_t'(fetch_en_q);
        RegBootMode: rdata_d = data_t'(bootmode_q);
        default:     rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign bus.gnt    = 1'b1;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

//--- rtl/periph_demux.sv
// ----------------------------------------------------------
// Peripheral region demux
// Routes the SoC control window to the register block and
// answers every other address with an error response
// ----------------------------------------------------------

`timescale 1ns/1ps

module periph_demux import safety_island_pkg::*; #(
  parameter addr_t PeriphBaseAddr = PeriphOffset
) (
  input  logic clk_i,
  input  logic rst_ni,
  mem_bus_if.target    bus,
  mem_bus_if.initiator ctrl
);

  addr_t ctrl_off;
  logic  in_ctrl;
  logic  err_req;
  logic  err_q;

  // Offset inside the control window, wraps for lower addresses
  assign ctrl_off = bus.addr - PeriphBaseAddr - SocCtrlOffset;
  assign in_ctrl  = ctrl_off < SocCtrlRange;
  assign err_req  = bus.req && !in_ctrl;

  // ----------------------------------------------------------
  // Request path
  // ----------------------------------------------------------
  assign ctrl.req   = bus.req && in_ctrl;
  assign ctrl.we    = bus.we;
  assign ctrl.be    = bus.be;
  assign ctrl.addr  = ctrl_off;
  assign ctrl.wdata = bus.wdata;

  // Error responder never stalls
  assign bus.gnt = in_ctrl ? ctrl.gnt : 1'b1;

  // ----------------------------------------------------------
  // Response path
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_req;
    end
  end

  assign bus.rvalid = err_q || ctrl.rvalid;
  assign bus.rdata  = err_q ? ErrorRdata : ctrl.rdata;
  assign bus.err    = err_q || ctrl.err;

endmodule

//--- rtl/sram_bank.sv
// ----------------------------------------------------------
// SRAM bank
// Word-addressed memory with byte enables, always granted,
// read data one cycle after the request
// ----------------------------------------------------------

`timescale 1ns/1ps

module sram_bank import safety_island_pkg::*; #(
  parameter int unsigned NumWords = 1024
) (
  input  logic clk_i,
  input  logic rst_ni,
  mem_bus_if.target bus
);

  localparam int unsigned IdxWidth = (NumWords > 1) ? $clog2(NumWords) : 1;

  data_t                mem_q [NumWords];
  data_t                rdata_q;
  logic                 rvalid_q;
  logic [IdxWidth-1:0]  idx;

  // Word index from the bits below the bank size
  assign idx = bus.addr[IdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (bus.be[b]) begin
            mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.gnt    = 1'b1;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

//--- rtl/bus_xbar.sv
// ----------------------------------------------------------
// Island crossbar
// Decodes initiator addresses onto two SRAM banks and the
// peripheral region, arbitrates round-robin per target and
// routes the responses back one cycle after the grant
// ----------------------------------------------------------

`timescale 1ns/1ps

module bus_xbar import safety_island_pkg::*; #(
  parameter addr_t       BaseAddr     = '0,
  parameter int unsigned BankNumBytes = 4096
) (
  input  logic clk_i,
  input  logic rst_ni,
  mem_bus_if.target    init_i [NumInitiators],
  mem_bus_if.initiator tgt_o  [NumTargets]
);

  localparam addr_t BankSize = addr_t'(BankNumBytes);

  // Initiator side
  logic         in_req    [NumInitiators];
  logic         in_we     [NumInitiators];
  be_t          in_be     [NumInitiators];
  addr_t        in_addr   [NumInitiators];
  data_t        in_wdata  [NumInitiators];
  logic         in_gnt    [NumInitiators];
  xbar_target_e in_sel    [NumInitiators];

  // Target side
  logic         t_req     [NumTargets];
  logic         t_gnt     [NumTargets];
  logic         t_rvalid  [NumTargets];
  data_t        t_rdata   [NumTargets];
  logic         t_err     [NumTargets];

  // Winning initiator per target, and the last one granted there
  logic [NumTargets-1:0] win;
  logic [NumTargets-1:0] last_q;
  logic [NumTargets-1:0][NumInitiators-1:0] hit;

  // Outstanding response per initiator
  logic         pend_q     [NumInitiators];
  xbar_target_e pend_tgt_q [NumInitiators];

  // ----------------------------------------------------------
  // Address decode and arbitration
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NumInitiators; i++) begin
      if (in_addr[i] - BaseAddr < BankSize) begin
        in_sel[i] = TgtBank0;
      end else if (in_addr[i] - BaseAddr < 2 * BankSize) begin
        in_sel[i] = TgtBank1;
      end else begin
        // Everything else, mapped or not, goes to the peripherals
        in_sel[i] = TgtPeriph;
      end
    end
  end

  always_comb begin
    for (int t = 0; t < NumTargets; t++) begin
      for (int i = 0; i < NumInitiators; i++) begin
        hit[t][i] = in_req[i] && (in_sel[i] == xbar_target_e'(t));
      end
      // On contention the initiator not granted last time wins
      win[t]   = (hit[t][0] && hit[t][1]) ? ~last_q[t] : hit[t][1];
      t_req[t] = |hit[t];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= '1;
      for (int i = 0; i < NumInitiators; i++) begin
        pend_q[i]     <= 1'b0;
        pend_tgt_q[i] <= TgtBank0;
      end
    end else begin
      for (int t = 0; t < NumTargets; t++) begin
        if (t_req[t] && t_gnt[t]) begin
          last_q[t] <= win[t];
        end
      end
      for (int i = 0; i < NumInitiators; i++) begin
        pend_q[i] <= in_gnt[i];
        if (in_gnt[i]) begin
          pend_tgt_q[i] <= in_sel[i];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Port wiring
  // ----------------------------------------------------------
  for (genvar i = 0; i < NumInitiators; i++) begin : gen_init
    assign in_req[i]   = init_i[i].req;
    assign in_we[i]    = init_i[i].we;
    assign in_be[i]    = init_i[i].be;
    assign in_addr[i]  = init_i[i].addr;
    assign in_wdata[i] = init_i[i].wdata;

    assign in_gnt[i] = in_req[i] && (win[in_sel[i]] == 1'(i)) && t_gnt[in_sel[i]];

    assign init_i[i].gnt    = in_gnt[i];
    assign init_i[i].rvalid = pend_q[i] && t_rvalid[pend_tgt_q[i]];
    assign init_i[i].rdata  = t_rdata[pend_tgt_q[i]];
    assign init_i[i].err    = pend_q[i] && t_err[pend_tgt_q[i]];
  end

  for (genvar t = 0; t < NumTargets; t++) begin : gen_tgt
    assign tgt_o[t].req   = t_req[t];
    assign tgt_o[t].we    = in_we[win[t]];
    assign tgt_o[t].be    = in_be[win[t]];
    assign tgt_o[t].addr  = in_addr[win[t]];
    assign tgt_o[t].wdata = in_wdata[win[t]];

    assign t_gnt[t]    = tgt_o[t].gnt;
    assign t_rvalid[t] = tgt_o[t].rvalid;
    assign t_rdata[t]  = tgt_o[t].rdata;
    assign t_err[t]    = tgt_o[t].err;
  end

endmodule

//--- rtl/mem_bus_if.sv
// ----------------------------------------------------------
// Memory bus interface
// req/gnt/rvalid protocol with one response per granted
// request, one cycle after the grant
// ----------------------------------------------------------

`timescale 1ns/1ps

interface mem_bus_if import safety_island_pkg::*; ();

  logic  req;
  logic  gnt;
  logic  rvalid;
  logic  we;
  be_t   be;
  addr_t addr;
  data_t wdata;
  data_t rdata;
  logic  err;

  modport initiator (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport target (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

//--- rtl/safety_island_pkg.sv
// ----------------------------------------------------------
// Safety island package
// Bus widths, memory map and shared types of the island's
// memory interconnect
// ----------------------------------------------------------

package safety_island_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Crossbar ports
  localparam int unsigned NumInitiators = 2;
  localparam int unsigned NumTargets    = 3;

  typedef enum logic [1:0] {
    TgtBank0  = 2'd0,
    TgtBank1  = 2'd1,
    TgtPeriph = 2'd2
  } xbar_target_e;

  // ----------------------------------------------------------
  // Memory map, relative to the island base
  // ----------------------------------------------------------
  localparam addr_t PeriphOffset  = 32'h0020_0000;
  localparam addr_t AddrRange     = 32'h0080_0000;
  localparam addr_t SocCtrlOffset = 32'h0000_0000;
  localparam addr_t SocCtrlRange  = 32'h0000_1000;
  localparam addr_t BootRomOffset = 32'h0000_1000;

  // Returned for every unmapped access
  localparam data_t ErrorRdata = 32'hBADC_AB1E;

  typedef enum logic [1:0] {
    BootJtag    = 2'd0,
    BootPreload = 2'd1,
    BootFlash   = 2'd2
  } bootmode_e;

  // SoC control register offsets within its window
  localparam int unsigned RegOffWidth = $clog2(SocCtrlRange);

  typedef enum logic [RegOffWidth-1:0] {
    RegBootAddr = 12'h000,
    RegFetchEn  = 12'h004,
    RegBootMode = 12'h008
  } soc_ctrl_reg_e;

endpackage
